// ==== rtl/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_ADDR_W 14
`define XLEN       32

// architectural csr addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// software-writable fields
`define CRMD_WMASK   32'h0000_01ff
`define PRMD_WMASK   32'h0000_0007
`define ECFG_WMASK   32'h0000_1bff
`define ESTAT_WMASK  32'h0000_0003
`define EENTRY_WMASK 32'hffff_ffc0

`define CRMD_RESET 32'h0000_0008 // da set
`define ECODE_TLBR 6'h3f

// exception cause ids
`define EXC_ADEF 7'h01
`define EXC_ALE  7'h02
`define EXC_TLBR 7'h03
`define EXC_PIL  7'h04
`define EXC_PIS  7'h05
`define EXC_PIF  7'h06
`define EXC_PME  7'h07
`define EXC_PPI  7'h08

`endif

// ==== rtl/csr_pkg.sv ====
`default_nettype none
`include "csr_settings.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`XLEN-1:0]       csr_data_t;
    typedef logic [5:0]             ecode_t;
    typedef logic [8:0]             esubcode_t;
    typedef logic [6:0]             exc_cause_t;
    typedef logic [7:0]             hwi_t;

    // one software write
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wreq_t;

    // one-hot register write selects
    typedef struct packed {
        logic crmd;
        logic prmd;
        logic ecfg;
        logic estat;
        logic era;
        logic badv;
        logic eentry;
        logic save0;
        logic save1;
        logic save2;
        logic save3;
        logic tid;
        logic tcfg;
        logic ticlr;
    } csr_wsel_t;

    typedef struct packed {
        csr_data_t  pc;
        csr_data_t  addr;        // faulting data address
        ecode_t     ecode;
        esubcode_t  esubcode;
        exc_cause_t cause;
        logic       inst_fault;  // fault came from the fetch side
    } trap_info_t;

endpackage

`default_nettype wire

// ==== rtl/csr_write_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "csr_settings.svh"

module csr_write_decode
    import csr_pkg::*;
(
    input  csr_wreq_t wreq_i,
    output csr_wsel_t write_sel_o,
    output csr_data_t wdata_o
);

    logic wr_en;

    assign wr_en = wreq_i.en;

    // exception and mode registers
    assign write_sel_o.crmd   = wr_en && (wreq_i.addr == `CSR_CRMD);
    assign write_sel_o.prmd   = wr_en && (wreq_i.addr == `CSR_PRMD);
    assign write_sel_o.ecfg   = wr_en && (wreq_i.addr == `CSR_ECFG);
    assign write_sel_o.estat  = wr_en && (wreq_i.addr == `CSR_ESTAT);
    assign write_sel_o.era    = wr_en && (wreq_i.addr == `CSR_ERA);
    assign write_sel_o.badv   = wr_en && (wreq_i.addr == `CSR_BADV);
    assign write_sel_o.eentry = wr_en && (wreq_i.addr == `CSR_EENTRY);

    // scratch
    assign write_sel_o.save0  = wr_en && (wreq_i.addr == `CSR_SAVE0);
    assign write_sel_o.save1  = wr_en && (wreq_i.addr == `CSR_SAVE1);
    assign write_sel_o.save2  = wr_en && (wreq_i.addr == `CSR_SAVE2);
    assign write_sel_o.save3  = wr_en && (wreq_i.addr == `CSR_SAVE3);

    // tval is read only and gets no select
    assign write_sel_o.tid    = wr_en && (wreq_i.addr == `CSR_TID);
    assign write_sel_o.tcfg   = wr_en && (wreq_i.addr == `CSR_TCFG);
    assign write_sel_o.ticlr  = wr_en && (wreq_i.addr == `CSR_TICLR);

    assign wdata_o = wreq_i.data;

endmodule

`default_nettype wire

// ==== rtl/csr_trap_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "csr_settings.svh"

module csr_trap_regs
    import csr_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  csr_wsel_t  write_sel_i,
    input  csr_data_t  wdata_i,
    input  wire        exception_i,
    input  wire        ertn_i,
    input  trap_info_t trap_i,
    input  hwi_t       hwi_i,
    input  wire        timer_irq_i,
    output csr_data_t  crmd_o,
    output csr_data_t  prmd_o,
    output csr_data_t  ecfg_o,
    output csr_data_t  estat_o,
    output csr_data_t  era_o,
    output csr_data_t  badv_o,
    output csr_data_t  eentry_o,
    output logic       is_interrupt_o
);

    csr_data_t crmd_q;
    csr_data_t prmd_q;
    csr_data_t ecfg_q;
    csr_data_t estat_q;  // sw bits, ecode, esubcode
    csr_data_t era_q;
    csr_data_t badv_q;
    csr_data_t eentry_q;
    hwi_t      hwi_q;

    function automatic csr_data_t merge(input csr_data_t old_v, input csr_data_t new_v,
                                        input csr_data_t mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // crmd holds plv in 1:0, ie in 2, da in 3 and pg in 4
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= `CRMD_RESET;
        end else if (exception_i) begin
            crmd_q[2:0] <= 3'b000;
            if (trap_i.cause == `EXC_TLBR) begin
                crmd_q[4:3] <= 2'b01; // refill runs in direct mode
            end
        end else if (ertn_i) begin
            crmd_q[2:0] <= prmd_q[2:0];
            if (estat_q[21:16] == `ECODE_TLBR) begin
                crmd_q[4:3] <= 2'b10; // back to paging
            end
        end else if (write_sel_i.crmd) begin
            crmd_q <= merge(crmd_q, wdata_i, `CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (exception_i) begin
            prmd_q[2:0] <= crmd_q[2:0]; // pplv, pie
        end else if (write_sel_i.prmd) begin
            prmd_q <= merge(prmd_q, wdata_i, `PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_q   <= '0;
            eentry_q <= '0;
            hwi_q    <= '0;
        end else begin
            hwi_q <= hwi_i;
            if (write_sel_i.ecfg) begin
                ecfg_q <= merge(ecfg_q, wdata_i, `ECFG_WMASK);
            end
            if (write_sel_i.eentry) begin
                eentry_q <= merge(eentry_q, wdata_i, `EENTRY_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
            era_q   <= '0;
            badv_q  <= '0;
        end else if (exception_i) begin
            estat_q[21:16] <= trap_i.ecode;
            estat_q[30:22] <= trap_i.esubcode;
            era_q          <= trap_i.pc;
            case (trap_i.cause)
                `EXC_TLBR, `EXC_ALE, `EXC_PIL, `EXC_PIS,
                `EXC_PIF, `EXC_PME, `EXC_PPI: begin
                    badv_q <= trap_i.inst_fault ? trap_i.pc : trap_i.addr;
                end
                `EXC_ADEF: badv_q <= trap_i.pc;
                default:   badv_q <= '0;
            endcase
        end else begin
            if (write_sel_i.estat) begin
                estat_q <= merge(estat_q, wdata_i, `ESTAT_WMASK);
            end
            if (write_sel_i.era) begin
                era_q <= wdata_i;
            end
            if (write_sel_i.badv) begin
                badv_q <= wdata_i;
            end
        end
    end

    assign crmd_o   = crmd_q;
    assign prmd_o   = prmd_q;
    assign ecfg_o   = ecfg_q;
    assign estat_o  = estat_q | {20'b0, timer_irq_i, 1'b0, hwi_q, 2'b00};
    assign era_o    = era_q;
    assign badv_o   = badv_q;
    assign eentry_o = eentry_q;

    assign is_interrupt_o = crmd_q[2] && ((ecfg_q[12:0] & estat_o[12:0]) != 13'b0);

endmodule

`default_nettype wire

// ==== rtl/csr_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_timer
    import csr_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  csr_wsel_t write_sel_i,
    input  csr_data_t wdata_i,
    output csr_data_t tid_o,
    output csr_data_t tcfg_o,
    output csr_data_t tval_o,
    output logic      timer_irq_o
);

    csr_data_t tid_q;
    csr_data_t tcfg_q;
    csr_data_t tval_q;
    logic      timer_en;
    logic      expire;

    assign expire = timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q    <= '0;
            tcfg_q   <= '0;
            tval_q   <= '0;
            timer_en <= 1'b0;
        end else begin
            if (write_sel_i.tid) begin
                tid_q <= wdata_i;
            end
            if (write_sel_i.tcfg) begin
                tcfg_q   <= wdata_i;
                tval_q   <= {wdata_i[31:2], 2'b00}; // initval
                timer_en <= wdata_i[0];
            end else if (expire) begin
                if (tcfg_q[1]) begin
                    tval_q <= {tcfg_q[31:2], 2'b00}; // periodic reload
                end else begin
                    tval_q   <= '1;
                    timer_en <= 1'b0;
                end
            end else if (timer_en) begin
                tval_q <= tval_q - 1'b1;
            end
        end
    end

    // clear has priority over a new expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq_o <= 1'b0;
        end else if (write_sel_i.ticlr && wdata_i[0]) begin
            timer_irq_o <= 1'b0;
        end else if (expire) begin
            timer_irq_o <= 1'b1;
        end
    end

    assign tid_o  = tid_q;
    assign tcfg_o = tcfg_q;
    assign tval_o = tval_q;

endmodule

`default_nettype wire

// ==== rtl/csr_save_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_save_regs
    import csr_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  csr_wsel_t write_sel_i,
    input  csr_data_t wdata_i,
    output csr_data_t save0_o,
    output csr_data_t save1_o,
    output csr_data_t save2_o,
    output csr_data_t save3_o
);

    csr_data_t  save_q [4];
    logic [3:0] save_we;

    assign save_we = {write_sel_i.save3, write_sel_i.save2,
                      write_sel_i.save1, write_sel_i.save0};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                save_q[i] <= '0;
            end else if (save_we[i]) begin
                save_q[i] <= wdata_i;
            end
        end
    end

    assign save0_o = save_q[0];
    assign save1_o = save_q[1];
    assign save2_o = save_q[2];
    assign save3_o = save_q[3];

endmodule

`default_nettype wire

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "csr_settings.svh"

module csr_read_mux
    import csr_pkg::*;
(
    input  wire       rd_en_i,
    input  csr_addr_t rd_addr_i,
    input  csr_data_t crmd_i,
    input  csr_data_t prmd_i,
    input  csr_data_t ecfg_i,
    input  csr_data_t estat_i,
    input  csr_data_t era_i,
    input  csr_data_t badv_i,
    input  csr_data_t eentry_i,
    input  csr_data_t save0_i,
    input  csr_data_t save1_i,
    input  csr_data_t save2_i,
    input  csr_data_t save3_i,
    input  csr_data_t tid_i,
    input  csr_data_t tcfg_i,
    input  csr_data_t tval_i,
    output csr_data_t rd_data_o
);

    csr_data_t sel_data;

    always_comb begin
        case (rd_addr_i)
            `CSR_CRMD:   sel_data = crmd_i;
            `CSR_PRMD:   sel_data = prmd_i;
            `CSR_ECFG:   sel_data = ecfg_i;
            `CSR_ESTAT:  sel_data = estat_i;
            `CSR_ERA:    sel_data = era_i;
            `CSR_BADV:   sel_data = badv_i;
            `CSR_EENTRY: sel_data = eentry_i;
            `CSR_SAVE0:  sel_data = save0_i;
            `CSR_SAVE1:  sel_data = save1_i;
            `CSR_SAVE2:  sel_data = save2_i;
            `CSR_SAVE3:  sel_data = save3_i;
            `CSR_TID:    sel_data = tid_i;
            `CSR_TCFG:   sel_data = tcfg_i;
            `CSR_TVAL:   sel_data = tval_i;
            `CSR_TICLR:  sel_data = '0; // write-only clear port
            default:     sel_data = '0;
        endcase
    end

    assign rd_data_o = rd_en_i ? sel_data : '0;

endmodule

`default_nettype wire

// ==== rtl/csr_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_core
    import csr_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  csr_wreq_t  wreq_i,
    input  wire        exception_i,
    input  wire        ertn_i,
    input  trap_info_t trap_i,
    input  hwi_t       hwi_i,
    input  wire        rd_en_i,
    input  csr_addr_t  rd_addr_i,
    output csr_data_t  rd_data_o,
    output csr_data_t  crmd_o,
    output csr_data_t  era_o,
    output csr_data_t  eentry_o,
    output logic       is_interrupt_o
);

    csr_wsel_t write_sel;
    csr_data_t wdata;
    logic      timer_irq;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t badv;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tid;
    csr_data_t tcfg;
    csr_data_t tval;

    csr_write_decode i_write_decode (
        .wreq_i      (wreq_i),
        .write_sel_o (write_sel),
        .wdata_o     (wdata)
    );

    csr_trap_regs i_trap_regs (
        .clk            (clk),
        .rst            (rst),
        .write_sel_i    (write_sel),
        .wdata_i        (wdata),
        .exception_i    (exception_i),
        .ertn_i         (ertn_i),
        .trap_i         (trap_i),
        .hwi_i          (hwi_i),
        .timer_irq_i    (timer_irq),
        .crmd_o         (crmd_o),
        .prmd_o         (prmd),
        .ecfg_o         (ecfg),
        .estat_o        (estat),
        .era_o          (era_o),
        .badv_o         (badv),
        .eentry_o       (eentry_o),
        .is_interrupt_o (is_interrupt_o)
    );

    csr_timer i_timer (
        .clk         (clk),
        .rst         (rst),
        .write_sel_i (write_sel),
        .wdata_i     (wdata),
        .tid_o       (tid),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .timer_irq_o (timer_irq)
    );

    csr_save_regs i_save_regs (
        .clk         (clk),
        .rst         (rst),
        .write_sel_i (write_sel),
        .wdata_i     (wdata),
        .save0_o     (save0),
        .save1_o     (save1),
        .save2_o     (save2),
        .save3_o     (save3)
    );

    csr_read_mux i_read_mux (
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .crmd_i    (crmd_o),
        .prmd_i    (prmd),
        .ecfg_i    (ecfg),
        .estat_i   (estat),
        .era_i     (era_o),
        .badv_i    (badv),
        .eentry_i  (eentry_o),
        .save0_i   (save0),
        .save1_i   (save1),
        .save2_i   (save2),
        .save3_i   (save3),
        .tid_i     (tid),
        .tcfg_i    (tcfg),
        .tval_i    (tval),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== testbench/csr_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_checker
    import csr_pkg::*;
(
    input wire        clk,
    input wire        rst,
    input wire        exception_i,
    input trap_info_t trap_i,
    input csr_data_t  crmd_i,
    input csr_data_t  era_i,
    input wire        is_interrupt_i
);

    int fail_count = 0; // summed into the testbench total

    // no pending interrupt is reported while ie is clear
    irq_needs_ie: assert property (@(posedge clk) disable iff (rst)
        !crmd_i[2] |-> !is_interrupt_i)
        else begin
            $error("is_interrupt_o high with crmd ie clear");
            fail_count++;
        end

    trap_clears_mode: assert property (@(posedge clk) disable iff (rst)
        exception_i |=> (crmd_i[2:0] == 3'b000))
        else begin
            $error("crmd plv/ie not cleared after exception");
            fail_count++;
        end

    trap_saves_pc: assert property (@(posedge clk) disable iff (rst)
        exception_i |=> (era_i == $past(trap_i.pc)))
        else begin
            $error("era does not hold the trapping pc");
            fail_count++;
        end

endmodule

bind csr_core csr_checker i_checker (
    .clk            (clk),
    .rst            (rst),
    .exception_i    (exception_i),
    .trap_i         (trap_i),
    .crmd_i         (crmd_o),
    .era_i          (era_o),
    .is_interrupt_i (is_interrupt_o)
);

`default_nettype wire

// ==== testbench/csr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "csr_settings.svh"

module csr_tb
    import csr_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TIMER_INIT = 16; // multiple of 4 since the low tcfg bits are mode bits

    // rough cycle budget of each test
    localparam int RESET_LEN    = 40;
    localparam int MASK_LEN     = 160;
    localparam int TRAP_LEN     = 80;
    localparam int ONESHOT_LEN  = TIMER_INIT + 40;
    localparam int PERIODIC_LEN = 2 * TIMER_INIT + 50;
    localparam int IRQ_LEN      = 8 * 12 + TIMER_INIT + 40;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_LEN + MASK_LEN + TRAP_LEN + ONESHOT_LEN
                                          + PERIODIC_LEN + IRQ_LEN);

    logic       clk;
    logic       rst;
    csr_wreq_t  wreq;
    logic       exception;
    logic       ertn;
    trap_info_t trap;
    hwi_t       hwi;
    logic       rd_en;
    csr_addr_t  rd_addr;
    csr_data_t  rd_data;
    csr_data_t  crmd;
    csr_data_t  era;
    csr_data_t  eentry;
    logic       is_interrupt;

    int    seed;
    int    errors;
    string test_name;

    csr_addr_t kept_addrs [15] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
                                   `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1,
                                   `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG,
                                   `CSR_TICLR, `CSR_TVAL};

    csr_core i_dut (
        .clk            (clk),
        .rst            (rst),
        .wreq_i         (wreq),
        .exception_i    (exception),
        .ertn_i         (ertn),
        .trap_i         (trap),
        .hwi_i          (hwi),
        .rd_en_i        (rd_en),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data),
        .crmd_o         (crmd),
        .era_o          (era),
        .eentry_o       (eentry),
        .is_interrupt_o (is_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
        csr_wreq_t req;
        req.en   = 1'b1;
        req.addr = addr;
        req.data = data;
        @(posedge clk);
        wreq <= req;
        @(posedge clk);
        wreq.en <= 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic check_read(input csr_addr_t addr, input csr_data_t exp);
        csr_data_t v;
        csr_read(addr, v);
        check_data($sformatf("%s @%h", test_name, addr), exp, v);
    endtask

    task automatic raise_exception(input trap_info_t t);
        @(posedge clk);
        trap      <= t;
        exception <= 1'b1;
        @(posedge clk);
        exception <= 1'b0;
    endtask

    task automatic raise_ertn();
        @(posedge clk);
        ertn <= 1'b1;
        @(posedge clk);
        ertn <= 1'b0;
    endtask

    function automatic csr_data_t write_mask(input csr_addr_t addr);
        case (addr)
            `CSR_CRMD:   return `CRMD_WMASK;
            `CSR_PRMD:   return `PRMD_WMASK;
            `CSR_ECFG:   return `ECFG_WMASK;
            `CSR_ESTAT:  return `ESTAT_WMASK;
            `CSR_EENTRY: return `EENTRY_WMASK;
            `CSR_TICLR:  return '0; // clear port reads zero
            default:     return '1;
        endcase
    endfunction

    function automatic csr_data_t expected_badv(input trap_info_t t);
        case (t.cause)
            `EXC_ADEF: return t.pc;
            `EXC_ALE, `EXC_TLBR, `EXC_PIL, `EXC_PIS, `EXC_PIF, `EXC_PME, `EXC_PPI:
                return t.inst_fault ? t.pc : t.addr;
            default:   return '0;
        endcase
    endfunction

    function automatic trap_info_t random_trap();
        trap_info_t t;
        t.pc         = $random(seed);
        t.addr       = $random(seed);
        t.ecode      = ecode_t'($random(seed));
        t.esubcode   = esubcode_t'($random(seed));
        t.cause      = exc_cause_t'($random(seed) & 32'hf); // fault and non-fault causes
        t.inst_fault = 1'($random(seed));
        return t;
    endfunction

    // polls estat bit 11 with start cycles already counted
    task automatic wait_timer_flag(input int start);
        csr_data_t st;
        int        n;
        logic      seen;
        n    = start;
        seen = 1'b0;
        while (!seen && n < TIMER_INIT + 3) begin
            csr_read(`CSR_ESTAT, st);
            seen = st[11];
            n++;
        end
        if (!seen) begin
            $display("%s: timer flag did not rise within %0d cycles", test_name,
                     TIMER_INIT + 3);
            errors++;
        end
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_read(`CSR_CRMD, `CRMD_RESET);
        for (int i = 1; i < 15; i++) begin
            check_read(kept_addrs[i], '0);
        end
        check_bit(test_name, 1'b0, is_interrupt);
        check_data("reset crmd_o", `CRMD_RESET, crmd);
        @(posedge clk);
        rd_en   <= 1'b0;
        rd_addr <= `CSR_CRMD;
        @(negedge clk);
        check_data("reset rd_en low", '0, rd_data);
    endtask

    task automatic test_write_masks();
        csr_data_t wval;
        csr_data_t exp;
        csr_data_t keep;
        csr_addr_t a;
        hwi_t      hwi_v;
        test_name = "write_masks";
        hwi_v = hwi_t'($random(seed));
        @(posedge clk);
        hwi <= hwi_v;
        for (int i = 0; i < 14; i++) begin // tval is read only
            a = kept_addrs[i];
            for (int j = 0; j < 2; j++) begin
                wval = (j == 0) ? '1 : $random(seed);
                csr_write(a, wval);
                exp = wval & write_mask(a);
                if (a == `CSR_ESTAT) begin
                    exp = exp | (csr_data_t'(hwi_v) << 2); // live hwi lines
                end
                check_read(a, exp);
                if (a == `CSR_EENTRY) begin
                    check_data("write_masks eentry_o", exp, eentry);
                end
            end
        end
        csr_read(`CSR_SAVE0, keep);
        csr_write(14'h3ff, $random(seed));
        check_read(14'h3ff, '0);
        check_read(`CSR_SAVE0, keep);
        @(posedge clk);
        hwi <= '0;
        csr_write(`CSR_CRMD, `CRMD_RESET);
        csr_write(`CSR_ECFG, '0);
        csr_write(`CSR_ESTAT, '0);
        csr_write(`CSR_TCFG, '0);
        csr_write(`CSR_TICLR, 32'h1);
    endtask

    task automatic test_trap();
        trap_info_t t;
        csr_data_t  exp_crmd;
        test_name = "trap";
        for (int k = 0; k < 6; k++) begin
            t = random_trap();
            csr_write(`CSR_CRMD, 32'h0000_0017); // plv 3, ie, pg
            raise_exception(t);
            exp_crmd = 32'h0000_0017 & ~32'h7;
            if (t.cause == `EXC_TLBR) begin
                exp_crmd = (exp_crmd & ~32'h18) | 32'h8;
            end
            check_read(`CSR_PRMD, 32'h7);
            check_read(`CSR_CRMD, exp_crmd);
            check_data("trap crmd_o", exp_crmd, crmd);
            check_read(`CSR_ERA, t.pc);
            check_data("trap era_o", t.pc, era);
            check_read(`CSR_ESTAT, {1'b0, t.esubcode, t.ecode, 16'h0});
            check_read(`CSR_BADV, expected_badv(t));
        end
        // refill entry then return to paging
        t       = random_trap();
        t.cause = `EXC_TLBR;
        t.ecode = `ECODE_TLBR;
        csr_write(`CSR_CRMD, 32'h0000_0017);
        raise_exception(t);
        check_read(`CSR_CRMD, 32'h0000_0008);
        check_read(`CSR_PRMD, 32'h7);
        check_read(`CSR_BADV, expected_badv(t));
        raise_ertn();
        check_read(`CSR_CRMD, 32'h0000_0017);
        csr_write(`CSR_CRMD, `CRMD_RESET);
    endtask

    task automatic test_oneshot();
        csr_data_t st;
        test_name = "oneshot";
        csr_write(`CSR_TCFG, TIMER_INIT | 1);
        check_read(`CSR_TVAL, csr_data_t'(TIMER_INIT - 1));
        check_read(`CSR_TVAL, csr_data_t'(TIMER_INIT - 2));
        wait_timer_flag(2);
        check_read(`CSR_TVAL, '1);
        check_read(`CSR_TVAL, '1);
        csr_write(`CSR_TICLR, 32'h1);
        csr_read(`CSR_ESTAT, st);
        check_bit(test_name, 1'b0, st[11]);
    endtask

    task automatic test_periodic();
        csr_data_t st;
        test_name = "periodic";
        csr_write(`CSR_TCFG, TIMER_INIT | 3);
        wait_timer_flag(0);
        csr_write(`CSR_TICLR, 32'h1);
        csr_read(`CSR_ESTAT, st);
        check_bit(test_name, 1'b0, st[11]);
        wait_timer_flag(1);
        csr_write(`CSR_TCFG, '0);
        csr_write(`CSR_TICLR, 32'h1);
        csr_read(`CSR_ESTAT, st);
        check_bit(test_name, 1'b0, st[11]);
    endtask

    task automatic test_interrupt();
        csr_data_t ecfg_v;
        csr_data_t sw_v;
        csr_data_t pend;
        hwi_t      hwi_v;
        logic      ie;
        logic      exp;
        test_name = "interrupt";
        for (int k = 0; k < 8; k++) begin
            ie     = k[0];
            hwi_v  = hwi_t'($random(seed));
            ecfg_v = $random(seed) & `ECFG_WMASK;
            sw_v   = $random(seed) & `ESTAT_WMASK;
            @(posedge clk);
            hwi <= hwi_v;
            csr_write(`CSR_ECFG, ecfg_v);
            csr_write(`CSR_ESTAT, sw_v);
            csr_write(`CSR_CRMD, ie ? 32'hc : 32'h8);
            pend = sw_v | (csr_data_t'(hwi_v) << 2);
            exp  = ie && ((ecfg_v[12:0] & pend[12:0]) != 13'b0);
            @(negedge clk);
            check_bit(test_name, exp, is_interrupt);
        end
        // timer line as the only source
        @(posedge clk);
        hwi <= '0;
        csr_write(`CSR_ESTAT, '0);
        csr_write(`CSR_ECFG, 32'h0000_0800);
        csr_write(`CSR_CRMD, 32'hc);
        csr_write(`CSR_TCFG, TIMER_INIT | 1);
        wait_timer_flag(0);
        check_bit(test_name, 1'b1, is_interrupt);
        csr_write(`CSR_CRMD, 32'h8);
        @(negedge clk);
        check_bit(test_name, 1'b0, is_interrupt);
        csr_write(`CSR_CRMD, 32'hc);
        @(negedge clk);
        check_bit(test_name, 1'b1, is_interrupt);
        csr_write(`CSR_TICLR, 32'h1);
        @(negedge clk);
        check_bit(test_name, 1'b0, is_interrupt);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed      = 36602;
        errors    = 0;
        rst       = 1'b1;
        wreq      = '0;
        exception = 1'b0;
        ertn      = 1'b0;
        trap      = '0;
        hwi       = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_write_masks();
        test_trap();
        test_oneshot();
        test_periodic();
        test_interrupt();

        repeat (2) @(posedge clk);
        errors = errors + i_dut.i_checker.fail_count;
        $display("Checks done: %0d errors (%0d from assertions)", errors,
                 i_dut.i_checker.fail_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_write_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_timer.sv
rtl/csr_save_regs.sv
rtl/csr_read_mux.sv
rtl/csr_core.sv
testbench/csr_checker.sv
testbench/csr_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= csr_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
VFLAGS     ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+100
PASS_MSG   := All tests passed!

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
